// ==== Makefile ====
SIM := obj_dir/Vtb_templateMatcher
SRCS := $(wildcard src/*.sv bench/*.sv)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

# rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_templateMatcher -f tb.f

clean:
	rm -rf obj_dir

// ==== bench/tb_templateMatcher.sv ====
`timescale 1ns/1ps

module tb_templateMatcher;
	import nccPkg::*;

	logic clk;
	logic rst;
	logic descValid;
	logic [PatchDim*PixelWidth-1:0] descPixels;
	logic windowValid;
	logic [PatchPixels*PixelWidth-1:0] windowPixels;
	logic windowDone;
	logic [ScoreWidth-1:0] bestScore;
	logic [IndexWidth-1:0] bestIndex;

	int descModel [PatchPixels];
	int winPix [PatchPixels];
	int bestWin [PatchPixels];
	int modelBest = 0;
	int modelIndex = 0;
	int frameIdx = 0;
	int errors = 0;
	int windowsSent = 0;
	int doneCount = 0;
	int cycles = 0;

	templateMatcher templateMatcher_inst (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descPixels(descPixels),
		.windowValid(windowValid),
		.windowPixels(windowPixels),
		.windowDone(windowDone),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

	bind templateMatcher templateMatcher_checker checker_inst (
		.clk(clk),
		.rst(rst),
		.windowValid(windowValid),
		.windowDone(windowDone),
		.bestIndex(bestIndex),
		.state(control.state)
	);

	initial begin
		clk = 0;
		forever #4 clk = ~clk;
	end

	// 48 windows over three frames take about 150 cycles
	always @(posedge clk) begin
		cycles++;
		if (!rst && windowDone) begin
			doneCount++;
		end
		if (cycles >= 2000) begin
			$display("Timeout: the run went past its cycle limit");
			$display("Checks failed");
			$finish;
		end
	end

	// leading one sets the exponent of the log value
	function automatic int logOf(input int pix);
		int mag;
		int e;
		mag = (pix < 0) ? -pix : pix;
		e = 0;
		for (int i = 0; i < PixelWidth; i++) begin
			if ((mag >> i) != 0) begin
				e = i;
			end
		end
		return e * (1 << FracBits) + (((mag << FracBits) >> e) % (1 << FracBits));
	endfunction

	// Mitchell product of two pixels
	function automatic int productOf(input int a, input int b);
		int s;
		int mag;
		if (a == 0 || b == 0) begin
			return 0;
		end
		s = logOf(a) + logOf(b);
		mag = (((1 << FracBits) + s % (1 << FracBits)) << (s >> FracBits)) >> FracBits;
		return ((a < 0) != (b < 0)) ? -mag : mag;
	endfunction

	function automatic int scoreOf();
		int sum;
		sum = 0;
		for (int i = 0; i < PatchPixels; i++) begin
			sum += productOf(descModel[i], winPix[i]);
		end
		return sum;
	endfunction

	// zero and -256 show up often on purpose
	function automatic int randomPixel();
		int pick;
		pick = $urandom_range(7);
		if (pick == 0) begin
			return 0;
		end
		if (pick == 1) begin
			return -256;
		end
		return int'($urandom_range(511)) - 256;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// four rows leave the row counter back at 0
	task automatic loadDescriptor();
		for (int r = 0; r < PatchDim; r++) begin
			descValid = 1;
			for (int c = 0; c < PatchDim; c++) begin
				descModel[r*PatchDim+c] = randomPixel();
				descPixels[c*PixelWidth +: PixelWidth] = PixelWidth'(descModel[r*PatchDim+c]);
			end
			tick();
		end
		descValid = 0;
	endtask

	task automatic runWindow(input bit holdValid);
		int expected;
		int mag;
		for (int i = 0; i < PatchPixels; i++) begin
			windowPixels[i*PixelWidth +: PixelWidth] = PixelWidth'(winPix[i]);
		end
		windowValid = 1;
		tick();
		compare("windowDone", 1, 32'(windowDone));
		// held valid in the score cycle must not start another window
		windowValid = holdValid;
		tick();
		windowValid = 0;
		compare("windowDone", 0, 32'(windowDone));
		expected = scoreOf();
		mag = (expected < 0) ? -expected : expected;
		if (frameIdx == 0 || mag > modelBest) begin
			modelBest = mag;
			modelIndex = frameIdx;
			bestWin = winPix;
		end
		frameIdx = (frameIdx + 1) % WindowsPerFrame;
		windowsSent++;
		compare("bestScore", modelBest, 32'(bestScore));
		compare("bestIndex", modelIndex, 32'(bestIndex));
	endtask

	task automatic runFrame(input int firstWin);
		for (int w = firstWin; w < WindowsPerFrame; w++) begin
			for (int i = 0; i < PatchPixels; i++) begin
				if (w == 3) begin
					winPix[i] = (i % 2 == 1) ? -256 : 255;
				end
				else if (w == 5) begin
					winPix[i] = 0;
				end
				else if (w != 9) begin
					winPix[i] = randomPixel();
				end
			end
			// window 9 repeats the frame's best so far to force a tie
			if (w == 9) begin
				winPix = bestWin;
			end
			runWindow($urandom_range(1) == 1);
			if ($urandom_range(3) == 0) begin
				tick();
			end
		end
	endtask

	initial begin
		void'($urandom(32'h3a72_5120));
		rst = 1;
		descValid = 0;
		windowValid = 0;
		descPixels = '0;
		windowPixels = '0;
		repeat (2) @(posedge clk);
		#1 rst = 0;
		compare("windowDone", 0, 32'(windowDone));
		compare("bestScore", 0, 32'(bestScore));
		compare("bestIndex", 0, 32'(bestIndex));

		loadDescriptor();
		runFrame(0);

		// an all-zero 17th window is smaller than any earlier best
		for (int i = 0; i < PatchPixels; i++) begin
			winPix[i] = 0;
		end
		runWindow(1);
		compare("bestIndex", 0, 32'(bestIndex));
		compare("bestScore", 0, 32'(bestScore));
		runFrame(1);

		// new rows change every later score
		loadDescriptor();
		runFrame(0);
		tick();
		compare("windowDone count", windowsSent, doneCount);

		errors += templateMatcher_inst.checker_inst.failCount;
		$display("errors: %0d, windows: %0d, done pulses: %0d", errors, windowsSent, doneCount);
		if (errors == 0) begin
			$display("All checks passed");
		end
		else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule : tb_templateMatcher

// ==== bench/templateMatcher_checker.sv ====
`timescale 1ns/1ps

module templateMatcher_checker (
	input logic clk,
	input logic rst,
	input logic windowValid,
	input logic windowDone,
	input logic [nccPkg::IndexWidth-1:0] bestIndex,
	input nccPkg::winState_t state
);
	import nccPkg::*;

	int failCount = 0;

	// one score cycle per accepted window
	doneSinglePulse: assert property (@(posedge clk) disable iff (rst)
		windowDone |=> !windowDone)
	else begin
		$error("windowDone was high in two consecutive cycles");
		failCount++;
	end

	// done only follows a window taken while idle
	doneAfterAccept: assert property (@(posedge clk) disable iff (rst)
		windowDone |-> $past(state == WIN_IDLE && windowValid))
	else begin
		$error("windowDone without an accepted window in the cycle before");
		failCount++;
	end

	// tracker only writes at the end of a score cycle
	indexAfterDone: assert property (@(posedge clk) disable iff (rst)
		(bestIndex != $past(bestIndex)) |-> $past(windowDone))
	else begin
		$error("bestIndex changed outside the cycle after windowDone");
		failCount++;
	end

endmodule : templateMatcher_checker

// ==== src/bestMatchTracker.sv ====
`timescale 1ns/1ps

module bestMatchTracker (
	input logic clk,
	input logic rst,
	matchCtrlIf.tracker ctl,
	input logic signed [nccPkg::ScoreWidth-1:0] score,
	output logic [nccPkg::ScoreWidth-1:0] bestScore,
	output logic [nccPkg::IndexWidth-1:0] bestIndex
);
	import nccPkg::*;

	logic [ScoreWidth-1:0] mag;
	logic frameStart;
	logic better;

	assign mag = score[ScoreWidth-1] ? ScoreWidth'(-score) : score;

	// window 0 opens a new frame and always replaces the best
	assign frameStart = (ctl.windowIndex == '0);

	// strictly greater, so a tie keeps the earlier window
	assign better = mag > bestScore;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			bestScore <= '0;
			bestIndex <= '0;
		end
		else if (ctl.scoreValid && (frameStart || better)) begin
			bestScore <= mag;
			bestIndex <= ctl.windowIndex;
		end
	end

endmodule : bestMatchTracker

// ==== src/correlationArray.sv ====
`timescale 1ns/1ps

module correlationArray (
	input logic clk,
	input logic rst,
	matchCtrlIf.array ctl,
	input logic [nccPkg::PatchDim*nccPkg::PixelWidth-1:0] descPixels,
	input logic [nccPkg::PatchPixels*nccPkg::PixelWidth-1:0] windowPixels,
	output logic signed [nccPkg::ScoreWidth-1:0] score
);
	import nccPkg::*;

	logVal_t descRowLog [PatchDim];
	logVal_t winLog [PatchPixels];
	logVal_t descReg [PatchPixels];
	logVal_t winReg [PatchPixels];
	logic signed [ScoreWidth-1:0] rowTotal [PatchDim];

	// logs of one incoming descriptor row
	for (genvar c = 0; c < PatchDim; c++) begin : gDescLog
		pixelLog2 descLog2 (
			.pixel(descPixels[c*PixelWidth +: PixelWidth]),
			.logOut(descRowLog[c])
		);
	end

	// logs of the whole window in parallel
	for (genvar p = 0; p < PatchPixels; p++) begin : gWinLog
		pixelLog2 winLog2 (
			.pixel(windowPixels[p*PixelWidth +: PixelWidth]),
			.logOut(winLog[p])
		);
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < PatchPixels; i++) begin
				descReg[i] <= '0;
				winReg[i] <= '0;
			end
		end
		else begin
			for (int r = 0; r < PatchDim; r++) begin
				for (int c = 0; c < PatchDim; c++) begin
					if (ctl.descWrite && ctl.descRow == RowWidth'(r)) begin
						descReg[r*PatchDim+c] <= descRowLog[c];
					end
				end
			end
			if (ctl.winLoad) begin
				for (int i = 0; i < PatchPixels; i++) begin
					winReg[i] <= winLog[i];
				end
			end
		end
	end

	// each PE row accumulates left to right
	for (genvar r = 0; r < PatchDim; r++) begin : gRow
		logic signed [ScoreWidth-1:0] acc [PatchDim+1];

		assign acc[0] = '0;

		for (genvar c = 0; c < PatchDim; c++) begin : gCol
			logVal_t d;
			logVal_t w;
			logic [LogSumWidth-1:0] logSum;
			logic [ShiftWidth-1:0] shifted;
			logic [ScoreWidth-1:0] prod;

			assign d = descReg[r*PatchDim+c];
			assign w = winReg[r*PatchDim+c];

			// multiply is an add in the log domain
			assign logSum = LogSumWidth'({d.exp, d.frac}) + LogSumWidth'({w.exp, w.frac});

			// Mitchell antilog shifts (1.F) left by E and truncates
			assign shifted = ShiftWidth'({1'b1, logSum[FracBits-1:0]})
				<< logSum[LogSumWidth-1:FracBits];
			assign prod = (d.zero || w.zero) ? '0 : ScoreWidth'(shifted[ShiftWidth-1:FracBits]);

			assign acc[c+1] = (d.sign ^ w.sign) ? acc[c] - signed'(prod) : acc[c] + signed'(prod);
		end

		assign rowTotal[r] = acc[PatchDim];
	end

	// patch sum
	always_comb begin
		score = '0;
		for (int r = 0; r < PatchDim; r++) begin
			score = score + rowTotal[r];
		end
	end

endmodule : correlationArray

// ==== src/matchControl.sv ====
`timescale 1ns/1ps

module matchControl (
	input logic clk,
	input logic rst,
	input logic windowValid,
	input logic descValid,
	matchCtrlIf.ctrl ctl,
	output logic windowDone
);
	import nccPkg::*;

	winState_t state;
	logic [RowWidth-1:0] rowCount;
	logic [IndexWidth-1:0] winCount;

	// descriptor rows load straight from the strobe
	assign ctl.descWrite = descValid;
	assign ctl.descRow = rowCount;

	// new windows are only taken while idle
	assign ctl.winLoad = (state == WIN_IDLE) && windowValid;
	assign ctl.scoreValid = (state == WIN_SCORE);
	assign ctl.windowIndex = winCount;
	assign windowDone = (state == WIN_SCORE);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			rowCount <= '0;
		end
		else if (descValid) begin
			if (rowCount == RowWidth'(PatchDim - 1)) begin
				rowCount <= '0;
			end
			else begin
				rowCount <= rowCount + 1'b1;
			end
		end
	end

	// one score cycle per accepted window
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= WIN_IDLE;
		end
		else begin
			case (state)
				WIN_IDLE: begin
					if (windowValid) begin
						state <= WIN_SCORE;
					end
				end
				WIN_SCORE: state <= WIN_IDLE;
				default: state <= WIN_IDLE;
			endcase
		end
	end

	// frame window counter wraps after the last window of a frame
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			winCount <= '0;
		end
		else if (state == WIN_SCORE) begin
			if (winCount == IndexWidth'(WindowsPerFrame - 1)) begin
				winCount <= '0;
			end
			else begin
				winCount <= winCount + 1'b1;
			end
		end
	end

endmodule : matchControl

// ==== src/matchCtrlIf.sv ====
`timescale 1ns/1ps

interface matchCtrlIf;
	import nccPkg::*;

	logic descWrite;
	logic [RowWidth-1:0] descRow;
	logic winLoad;
	logic scoreValid;
	logic [IndexWidth-1:0] windowIndex;

	// control side drives every strobe
	modport ctrl (output descWrite, descRow, winLoad, scoreValid, windowIndex);

	// log registers only need the load strobes
	modport array (input descWrite, descRow, winLoad);

	modport tracker (input scoreValid, windowIndex);

endinterface : matchCtrlIf

// ==== src/nccPkg.sv ====
package nccPkg;

	// pixel and patch geometry
	localparam int PixelWidth = 9;
	localparam int PatchDim = 4;
	localparam int PatchPixels = PatchDim * PatchDim;
	localparam int RowWidth = $clog2(PatchDim);

	// log format is exact for a 9-bit magnitude
	localparam int FracBits = 8;
	localparam int ExpWidth = 4;
	localparam int LogWidth = ExpWidth + FracBits;
	localparam int LogSumWidth = LogWidth + 1;
	// largest product exponent is twice the top pixel exponent
	localparam int ShiftWidth = FracBits + 1 + 2 * (PixelWidth - 1);

	localparam int ScoreWidth = 24;

	// search frame
	localparam int WindowsPerFrame = 16;
	localparam int IndexWidth = $clog2(WindowsPerFrame);

	typedef struct packed {
		logic sign;
		logic zero;
		logic [ExpWidth-1:0] exp;
		logic [FracBits-1:0] frac;
	} logVal_t;

	typedef enum logic {WIN_IDLE, WIN_SCORE} winState_t;

endpackage : nccPkg

// ==== src/pixelLog2.sv ====
`timescale 1ns/1ps

module pixelLog2 (
	input logic signed [nccPkg::PixelWidth-1:0] pixel,
	output nccPkg::logVal_t logOut
);
	import nccPkg::*;

	logic [PixelWidth-1:0] mag;
	logic [ExpWidth-1:0] lead;
	logic [PixelWidth-1:0] aligned;

	// -256 maps to a magnitude of 9'h100
	assign mag = pixel[PixelWidth-1] ? PixelWidth'(-pixel) : pixel;

	// leading one position is the integer part of the log
	always_comb begin
		lead = '0;
		for (int i = 0; i < PixelWidth; i++) begin
			if (mag[i]) begin
				lead = ExpWidth'(i);
			end
		end
	end

	// push the leading one up to bit FracBits so the bits below it form the fraction
	assign aligned = mag << (FracBits - int'(lead));

	always_comb begin
		logOut.sign = pixel[PixelWidth-1];
		logOut.zero = (mag == '0);
		logOut.exp = lead;
		logOut.frac = aligned[FracBits-1:0];
	end

endmodule : pixelLog2

// ==== src/templateMatcher.sv ====
`timescale 1ns/1ps

module templateMatcher (
	input logic clk,
	input logic rst,
	input logic descValid,
	input logic [nccPkg::PatchDim*nccPkg::PixelWidth-1:0] descPixels,
	input logic windowValid,
	input logic [nccPkg::PatchPixels*nccPkg::PixelWidth-1:0] windowPixels,
	output logic windowDone,
	output logic [nccPkg::ScoreWidth-1:0] bestScore,
	output logic [nccPkg::IndexWidth-1:0] bestIndex
);
	import nccPkg::*;

	logic signed [ScoreWidth-1:0] score;

	matchCtrlIf ctl ();

	// strobes, row counter and window counter
	matchControl control (
		.clk(clk),
		.rst(rst),
		.windowValid(windowValid),
		.descValid(descValid),
		.ctl(ctl.ctrl),
		.windowDone(windowDone)
	);

	// log registers and PE grid
	correlationArray array (
		.clk(clk),
		.rst(rst),
		.ctl(ctl.array),
		.descPixels(descPixels),
		.windowPixels(windowPixels),
		.score(score)
	);

	bestMatchTracker tracker (
		.clk(clk),
		.rst(rst),
		.ctl(ctl.tracker),
		.score(score),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

endmodule : templateMatcher

// ==== tb.f ====
src/nccPkg.sv
src/matchCtrlIf.sv
src/pixelLog2.sv
src/correlationArray.sv
src/matchControl.sv
src/bestMatchTracker.sv
src/templateMatcher.sv
bench/templateMatcher_checker.sv
bench/tb_templateMatcher.sv
